// ==== cmosDemosaic_params.svh ====
`ifndef CMOS_DEMOSAIC_PARAMS_SVH
`define CMOS_DEMOSAIC_PARAMS_SVH

// --------------------
// Sensor data widths
// --------------------

// Raw Bayer sample from the sensor
`define PIX_WIDTH 10

// Column and line counters
`define COUNT_WIDTH 16

// --------------------
// Line memory sizing
// --------------------

// Longest line one memory can hold is 2**LINE_ADDR_WIDTH pixels
`define LINE_ADDR_WIDTH 12

// Active pixels per line for 720p
`define COLUMN_VALID_DEFAULT 1280

`endif

// ==== cmosDemosaicPkg.sv ====
`include "cmosDemosaic_params.svh"

package cmosDemosaicPkg;

   // --------------------
   // Sample types
   // --------------------

   // One raw or colour sample
   typedef logic [`PIX_WIDTH-1:0] pixelT;

   // Room for four samples added together
   typedef logic [`PIX_WIDTH+1:0] pixelSumT;

   // Demosaic result, red in the top bits
   typedef struct packed {
      pixelT red;
      pixelT green;
      pixelT blue;
   } rgbT;

   // --------------------
   // Bayer sites
   // --------------------

   // Site of the centre pixel, first row is R G R G
   typedef enum logic [1:0] {
      RED_SITE,            // Even row, even column
      BLUE_SITE,           // Odd row, odd column
      GREEN_ON_RED_ROW,    // Even row, odd column
      GREEN_ON_BLUE_ROW    // Odd row, even column
   } bayerSiteT;

endpackage

// ==== lineTimingIf.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

interface lineTimingIf;

   logic                    go;           // High from the first frame start on
   logic [`COUNT_WIDTH-1:0] columnCount;  // Pixels seen so far in this line
   logic [`COUNT_WIDTH-1:0] lineCount;    // Lines completed in this frame
   logic                    rowReady;     // Three lines ready for demosaic
   logic                    centreOdd;    // Parity of the centre row

   // Counters and strobes come from the timing block
   modport source (
      output go,
      output columnCount,
      output lineCount,
      output rowReady,
      output centreOdd
   );

   // Write side and rotation of the line memories
   modport bank (
      input  go,
      input  columnCount,
      input  lineCount,
      input  rowReady
   );

   // Sweep start and row parity
   modport engine (
      input  rowReady,
      input  centreOdd
   );

endinterface

// ==== lineReadIf.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

interface lineReadIf;

   import cmosDemosaicPkg::*;

   logic [`LINE_ADDR_WIDTH-1:0] readAddr;  // Column to fetch from all three lines
   pixelT                       top;       // Oldest of the three lines
   pixelT                       middle;    // Centre row
   pixelT                       bottom;    // Most recent completed line

   // Taps follow readAddr by one clock

   modport bank (
      input  readAddr,
      output top,
      output middle,
      output bottom
   );

   modport engine (
      output readAddr,
      input  top,
      input  middle,
      input  bottom
   );

endinterface

// ==== pixelTiming.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

module pixelTiming (
   input  logic        PIX_CLK,
   input  logic        iRstn,
   input  logic        pixLv,
   input  logic        pixFv,
   lineTimingIf.source timing
);

   logic                    lvDly;
   logic                    fvDly;
   logic                    lvFall;
   logic                    fvRise;
   logic                    rowDone;
   logic                    goLevel;
   logic [`COUNT_WIDTH-1:0] colCount;
   logic [`COUNT_WIDTH-1:0] lineCnt;
   logic                    rowPulse;
   logic                    rowOdd;

   // --------------------
   // Edge detection
   // --------------------

   always_ff @(posedge PIX_CLK or negedge iRstn) begin
      if (!iRstn) begin
         lvDly <= 1'b0;
         fvDly <= 1'b0;
      end else begin
         lvDly <= pixLv;
         fvDly <= pixFv;
      end
   end

   assign lvFall = lvDly & ~pixLv;
   assign fvRise = ~fvDly & pixFv;

   // Third line or later just ended, lineCnt still holds the lines before it
   assign rowDone = goLevel & lvFall & (lineCnt > 1);

   // --------------------
   // Counters
   // --------------------

   always_ff @(posedge PIX_CLK or negedge iRstn) begin
      if (!iRstn) begin
         colCount <= '0;
         lineCnt  <= '0;
         goLevel  <= 1'b0;
      end else begin
         colCount <= pixLv ? colCount + 1'b1 : '0;   // Cleared in blanking
         if (fvRise)
            lineCnt <= '0;                          // New frame
         else if (lvFall)
            lineCnt <= lineCnt + 1'b1;
         if (fvRise)
            goLevel <= 1'b1;                        // Never drops again
      end
   end

   // Row pulse and centre parity, centre row is two lines back
   always_ff @(posedge PIX_CLK or negedge iRstn) begin
      if (!iRstn) begin
         rowPulse <= 1'b0;
         rowOdd   <= 1'b0;
      end else begin
         rowPulse <= rowDone;
         if (rowDone)
            rowOdd <= ~lineCnt[0];
      end
   end

   assign timing.go          = goLevel;
   assign timing.columnCount = colCount;
   assign timing.lineCount   = lineCnt;
   assign timing.rowReady    = rowPulse;
   assign timing.centreOdd   = rowOdd;

endmodule

// ==== lineRam.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

module lineRam (
   input  logic                          PIX_CLK,
   input  logic                          wrEn,
   input  logic [`LINE_ADDR_WIDTH-1:0]   wrAddr,
   input  cmosDemosaicPkg::pixelT        wrData,
   input  logic [`LINE_ADDR_WIDTH-1:0]   rdAddr,
   output cmosDemosaicPkg::pixelT        rdData
);

   import cmosDemosaicPkg::*;

   localparam int Depth = 2 ** `LINE_ADDR_WIDTH;

   pixelT mem [Depth];

   // --------------------
   // Write port
   // --------------------

   always_ff @(posedge PIX_CLK) begin
      if (wrEn)
         mem[wrAddr] <= wrData;
   end

   // Registered read, data one clock after the address
   always_ff @(posedge PIX_CLK) begin
      rdData <= mem[rdAddr];
   end

endmodule

// ==== lineBufferBank.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

module lineBufferBank #(
   parameter int ColumnValid = `COLUMN_VALID_DEFAULT
) (
   input  logic                   PIX_CLK,
   input  logic                   iRstn,
   input  cmosDemosaicPkg::pixelT pixData,
   lineTimingIf.bank              timing,
   lineReadIf.bank                lineRead
);

   import cmosDemosaicPkg::*;

   pixelT                       pixDly;
   logic                        wrActive;
   logic [`LINE_ADDR_WIDTH-1:0] wrAddr;
   logic [1:0]                  wrSlot;
   logic [1:0]                  topSel;
   logic [1:0]                  midSel;
   logic [1:0]                  botSel;
   pixelT                       ramQ [4];

   // --------------------
   // Write side
   // --------------------

   // Pixel lines up with the column count one clock later
   always_ff @(posedge PIX_CLK) begin
      pixDly <= pixData;
   end

   // Non-zero count means the previous clock carried a pixel
   assign wrActive = timing.go && (timing.columnCount != '0) &&
                     (timing.columnCount <= ColumnValid);
   assign wrAddr   = timing.columnCount[`LINE_ADDR_WIDTH-1:0] - 1'b1;
   assign wrSlot   = timing.lineCount[1:0];  // Arriving line goes to slot lineCount mod 4

   for (genvar i = 0; i < 4; i++) begin : gRam
      lineRam ramInst (
         .PIX_CLK (PIX_CLK),
         .wrEn    (wrActive && (wrSlot == 2'(i))),
         .wrAddr  (wrAddr),
         .wrData  (pixDly),
         .rdAddr  (lineRead.readAddr),
         .rdData  (ramQ[i])
      );
   end

   // --------------------
   // Rotation
   // --------------------

   // lineCount is already c here, oldest line c-3 is slot c+1
   always_ff @(posedge PIX_CLK or negedge iRstn) begin
      if (!iRstn) begin
         topSel <= 2'd0;
         midSel <= 2'd1;
         botSel <= 2'd2;
      end else if (timing.rowReady) begin
         topSel <= timing.lineCount[1:0] + 2'd1;
         midSel <= timing.lineCount[1:0] + 2'd2;
         botSel <= timing.lineCount[1:0] + 2'd3;   // Line c-1
      end
   end

   assign lineRead.top    = ramQ[topSel];
   assign lineRead.middle = ramQ[midSel];
   assign lineRead.bottom = ramQ[botSel];

endmodule

// ==== demosaicEngine.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

module demosaicEngine #(
   parameter int ColumnValid = `COLUMN_VALID_DEFAULT
) (
   input  logic                 PIX_CLK,
   input  logic                 iRstn,
   lineTimingIf.engine          timing,
   lineReadIf.engine            lineRead,
   output cmosDemosaicPkg::rgbT rgb,
   output logic                 rgbValid
);

   import cmosDemosaicPkg::*;

   typedef enum logic {ST_IDLE, ST_SWEEP} sweepStateT;

   localparam logic [`LINE_ADDR_WIDTH-1:0] LastAddr = `LINE_ADDR_WIDTH'(ColumnValid - 1);

   sweepStateT                  state;
   logic [`LINE_ADDR_WIDTH-1:0] readAddr;
   logic                        addrLive;
   logic                        tapLive;
   logic [`LINE_ADDR_WIDTH-1:0] tapCol;
   logic                        winReady;
   logic                        colOdd;
   pixelT                       topWin [3];
   pixelT                       midWin [3];
   pixelT                       botWin [3];
   pixelSumT                    crossSum;
   pixelSumT                    diagSum;
   pixelSumT                    horizSum;
   pixelSumT                    vertSum;
   bayerSiteT                   site;
   rgbT                         rgbNext;

   // --------------------
   // Address sweep
   // --------------------

   // Address 0 already sits on the bus while idle
   assign addrLive          = (state == ST_SWEEP) || timing.rowReady;
   assign lineRead.readAddr = readAddr;

   always_ff @(posedge PIX_CLK or negedge iRstn) begin
      if (!iRstn) begin
         state    <= ST_IDLE;
         readAddr <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (timing.rowReady) begin
                  state    <= ST_SWEEP;
                  readAddr <= `LINE_ADDR_WIDTH'(1);
               end
            end
            ST_SWEEP: begin
               if (readAddr == LastAddr) begin
                  state    <= ST_IDLE;
                  readAddr <= '0;
               end else begin
                  readAddr <= readAddr + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Valid flags follow the taps, window and output stages
   always_ff @(posedge PIX_CLK or negedge iRstn) begin
      if (!iRstn) begin
         tapLive  <= 1'b0;
         tapCol   <= '0;
         winReady <= 1'b0;
         colOdd   <= 1'b0;
         rgbValid <= 1'b0;
      end else begin
         tapLive  <= addrLive;
         tapCol   <= readAddr;
         winReady <= tapLive && (tapCol >= `LINE_ADDR_WIDTH'(2));   // Three columns loaded
         if (tapLive)
            colOdd <= (tapCol == '0) ? 1'b1 : ~colOdd;   // Centre is one column behind
         rgbValid <= winReady;
      end
   end

   // --------------------
   // 3x3 window
   // --------------------

   always_ff @(posedge PIX_CLK) begin
      if (tapLive) begin
         topWin[0] <= topWin[1];
         topWin[1] <= topWin[2];
         topWin[2] <= lineRead.top;
         midWin[0] <= midWin[1];
         midWin[1] <= midWin[2];
         midWin[2] <= lineRead.middle;
         botWin[0] <= botWin[1];
         botWin[1] <= botWin[2];
         botWin[2] <= lineRead.bottom;
      end
   end

   // Neighbour sums around the centre sample
   always_comb begin
      crossSum = pixelSumT'(midWin[0]) + pixelSumT'(midWin[2]) +
                 pixelSumT'(topWin[1]) + pixelSumT'(botWin[1]);
      diagSum  = pixelSumT'(topWin[0]) + pixelSumT'(topWin[2]) +
                 pixelSumT'(botWin[0]) + pixelSumT'(botWin[2]);
      horizSum = pixelSumT'(midWin[0]) + pixelSumT'(midWin[2]);
      vertSum  = pixelSumT'(topWin[1]) + pixelSumT'(botWin[1]);
   end

   always_comb begin
      case ({timing.centreOdd, colOdd})
         2'b00:   site = RED_SITE;
         2'b11:   site = BLUE_SITE;
         2'b01:   site = GREEN_ON_RED_ROW;
         default: site = GREEN_ON_BLUE_ROW;
      endcase
      rgbNext.green = midWin[1];   // Green sites keep their own sample
      case (site)
         RED_SITE: begin
            rgbNext.red   = midWin[1];
            rgbNext.green = pixelT'(crossSum >> 2);
            rgbNext.blue  = pixelT'(diagSum >> 2);
         end
         BLUE_SITE: begin
            rgbNext.red   = pixelT'(diagSum >> 2);
            rgbNext.green = pixelT'(crossSum >> 2);
            rgbNext.blue  = midWin[1];
         end
         GREEN_ON_RED_ROW: begin
            rgbNext.red  = pixelT'(horizSum >> 1);   // Red left and right
            rgbNext.blue = pixelT'(vertSum >> 1);
         end
         default: begin
            rgbNext.red  = pixelT'(vertSum >> 1);    // Red above and below
            rgbNext.blue = pixelT'(horizSum >> 1);
         end
      endcase
   end

   always_ff @(posedge PIX_CLK) begin
      if (winReady)
         rgb <= rgbNext;
   end

endmodule

// ==== cmosDemosaic.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

module cmosDemosaic #(
   parameter int ColumnValid = `COLUMN_VALID_DEFAULT
) (
   input  logic                    PIX_CLK,
   input  logic                    iRstn,
   input  logic [`PIX_WIDTH-1:0]   pixData,
   input  logic                    pixLv,
   input  logic                    pixFv,
   output cmosDemosaicPkg::pixelT  red,
   output cmosDemosaicPkg::pixelT  green,
   output cmosDemosaicPkg::pixelT  blue,
   output logic                    rgbValid,
   output logic [`COUNT_WIDTH-1:0] columnCount,
   output logic [`COUNT_WIDTH-1:0] lineCount,
   output logic                    go
);

   import cmosDemosaicPkg::*;

   rgbT rgbPix;

   lineTimingIf timingBus ();
   lineReadIf   readBus ();

   // --------------------
   // Datapath
   // --------------------

   pixelTiming timing_i (
      .PIX_CLK (PIX_CLK),
      .iRstn   (iRstn),
      .pixLv   (pixLv),
      .pixFv   (pixFv),
      .timing  (timingBus)
   );

   lineBufferBank #(.ColumnValid(ColumnValid)) bank_i (
      .PIX_CLK  (PIX_CLK),
      .iRstn    (iRstn),
      .pixData  (pixData),
      .timing   (timingBus),
      .lineRead (readBus)
   );

   demosaicEngine #(.ColumnValid(ColumnValid)) engine_i (
      .PIX_CLK  (PIX_CLK),
      .iRstn    (iRstn),
      .timing   (timingBus),
      .lineRead (readBus),
      .rgb      (rgbPix),
      .rgbValid (rgbValid)
   );

   assign red         = rgbPix.red;
   assign green       = rgbPix.green;
   assign blue        = rgbPix.blue;
   assign columnCount = timingBus.columnCount;   // Status for the sensor side
   assign lineCount   = timingBus.lineCount;
   assign go          = timingBus.go;

endmodule

// ==== cmosDemosaicTb.sv ====
`timescale 1ns/10ps
`include "cmosDemosaic_params.svh"

module cmosDemosaicTb;

   localparam int NumCols       = 12;
   localparam int NumRows       = 6;
   localparam int LineBlank     = 8;
   localparam int NumFrames     = 3;
   localparam int FirstPixLag   = 5;   // Registered line end to first RGB pixel
   localparam int TimeoutCycles = NumFrames * NumRows * 20 + 200;

   logic                    PIX_CLK;
   logic                    iRstn;
   logic [`PIX_WIDTH-1:0]   pixData;
   logic                    pixLv;
   logic                    pixFv;
   logic [`PIX_WIDTH-1:0]   red;
   logic [`PIX_WIDTH-1:0]   green;
   logic [`PIX_WIDTH-1:0]   blue;
   logic                    rgbValid;
   logic [`COUNT_WIDTH-1:0] columnCount;
   logic [`COUNT_WIDTH-1:0] lineCount;
   logic                    go;

   logic [`PIX_WIDTH-1:0] framePix [NumRows][NumCols];
   int expQ [$];          // Packed {red, green, blue} in row and column order
   int cycle = 0;
   int errCount = 0;
   int testStart = 0;
   int testsRun = 0;
   int testsFailed = 0;
   int rowsSeen = 0;
   int runLen = 0;
   int fallEdge = 0;
   int modelCol = 0;
   int modelLine = 0;
   logic lvPrev = 1'b0;
   logic fvPrev = 1'b0;
   logic validPrev = 1'b0;

   cmosDemosaic #(.ColumnValid(NumCols)) dut_i (
      .PIX_CLK     (PIX_CLK),
      .iRstn       (iRstn),
      .pixData     (pixData),
      .pixLv       (pixLv),
      .pixFv       (pixFv),
      .red         (red),
      .green       (green),
      .blue        (blue),
      .rgbValid    (rgbValid),
      .columnCount (columnCount),
      .lineCount   (lineCount),
      .go          (go)
   );

   initial begin
      PIX_CLK = 1'b0;
      forever #20 PIX_CLK = ~PIX_CLK;
   end

   // Run limit
   always @(posedge PIX_CLK) begin
      cycle++;
      if (cycle >= TimeoutCycles) begin
         $display("Timeout: no end of the run after %0d cycles", cycle);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic logMismatch(input string name, input int expVal, input int actVal);
      errCount++;
      $display("ERROR %s expected 0x%0h got 0x%0h at cycle %0d", name, expVal, actVal, cycle);
   endtask

   task automatic failCheck(input string msg);
      errCount++;
      $display("Check failed at cycle %0d: %s", cycle, msg);
   endtask

   task automatic endTest(input string name);
      int errs;
      errs = errCount - testStart;
      testsRun++;
      if (errs != 0)
         testsFailed++;
      $display("Test %0d %s: %s, %0d errors", testsRun, name, (errs == 0) ? "ok" : "failed", errs);
      testStart = errCount;
   endtask

   // --------------------
   // Reference model
   // --------------------

   task automatic fillFrame();
      for (int row = 0; row < NumRows; row++)
         for (int col = 0; col < NumCols; col++)
            framePix[row][col] = `PIX_WIDTH'($urandom());
   endtask

   // Centre rows and columns only, sums truncated as in the site rule
   task automatic queueExpected();
      int up, dn, lf, rt, ctr, r, g, b;
      for (int row = 1; row < NumRows - 1; row++) begin
         for (int col = 1; col < NumCols - 1; col++) begin
            ctr = framePix[row][col];
            up  = framePix[row-1][col];
            dn  = framePix[row+1][col];
            lf  = framePix[row][col-1];
            rt  = framePix[row][col+1];
            if (row % 2 == 0 && col % 2 == 0) begin
               r = ctr;
               g = (up + dn + lf + rt) / 4;
               b = (framePix[row-1][col-1] + framePix[row-1][col+1] +
                    framePix[row+1][col-1] + framePix[row+1][col+1]) / 4;
            end else if (row % 2 == 1 && col % 2 == 1) begin
               r = (framePix[row-1][col-1] + framePix[row-1][col+1] +
                    framePix[row+1][col-1] + framePix[row+1][col+1]) / 4;
               g = (up + dn + lf + rt) / 4;
               b = ctr;
            end else if (row % 2 == 0) begin
               r = (lf + rt) / 2;   // Green on a red row
               g = ctr;
               b = (up + dn) / 2;
            end else begin
               r = (up + dn) / 2;
               g = ctr;
               b = (lf + rt) / 2;
            end
            expQ.push_back((r << 20) | (g << 10) | b);
         end
      end
   endtask

   // --------------------
   // Output checks
   // --------------------

   goHolds: assert property (@(posedge PIX_CLK) disable iff (!iRstn) go |=> go)
      else failCheck("go dropped after the frame start");
   validNeedsGo: assert property (@(posedge PIX_CLK) disable iff (!iRstn) rgbValid |-> go)
      else failCheck("rgbValid high while go is low");

   // Negedge sampling, away from the driving edge
   always @(negedge PIX_CLK) begin
      int e;
      if (iRstn) begin
         assert (columnCount == modelCol) else logMismatch("columnCount", modelCol, columnCount);
         assert (lineCount == modelLine) else logMismatch("lineCount", modelLine, lineCount);
         if (!fvPrev && pixFv)
            modelLine = 0;
         else if (lvPrev && !pixLv)
            modelLine++;
         modelCol = pixLv ? modelCol + 1 : 0;
         if (lvPrev && !pixLv)
            fallEdge = cycle + 1;   // DUT registers the fall on the next edge
         lvPrev = pixLv;
         fvPrev = pixFv;
         if (rgbValid) begin
            if (!validPrev)
               assert (cycle - fallEdge == FirstPixLag)
                  else failCheck($sformatf("row started %0d cycles after line end",
                                           cycle - fallEdge));
            if (expQ.size() == 0) begin
               failCheck("rgbValid high with no pixel expected");
            end else begin
               e = expQ.pop_front();
               assert (red == e[29:20]) else logMismatch("red", e[29:20], red);
               assert (green == e[19:10]) else logMismatch("green", e[19:10], green);
               assert (blue == e[9:0]) else logMismatch("blue", e[9:0], blue);
            end
            runLen++;
         end else if (validPrev) begin
            assert (runLen == NumCols - 2)
               else failCheck($sformatf("row of %0d pixels instead of %0d", runLen, NumCols - 2));
            rowsSeen++;
            runLen = 0;
         end
         validPrev = rgbValid;
      end
   end

   // --------------------
   // Stimulus
   // --------------------

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(posedge PIX_CLK);
         pixLv   <= 1'b0;
         pixData <= '0;
      end
   endtask

   task automatic sendLine(input int row);
      for (int col = 0; col < NumCols; col++) begin
         @(posedge PIX_CLK);
         pixLv   <= 1'b1;
         pixData <= framePix[row][col];
      end
      idleCycles(LineBlank);
   endtask

   task automatic sendFrame();
      fillFrame();
      queueExpected();
      rowsSeen = 0;
      @(posedge PIX_CLK);
      pixFv <= 1'b1;
      idleCycles(2);
      for (int row = 0; row < NumRows; row++)
         sendLine(row);
      @(posedge PIX_CLK);
      pixFv <= 1'b0;
      while (expQ.size() != 0)
         @(posedge PIX_CLK);
      idleCycles(4);   // Last row finishes its run
      assert (rowsSeen == NumRows - 2)
         else failCheck($sformatf("%0d rows in the frame instead of %0d", rowsSeen, NumRows - 2));
   endtask

   initial begin
      iRstn   = 1'b0;
      pixData = '0;
      pixLv   = 1'b0;
      pixFv   = 1'b0;
      void'($urandom(32'h4266));
      repeat (3) @(posedge PIX_CLK);
      iRstn <= 1'b1;

      @(negedge PIX_CLK);
      assert (rgbValid == 1'b0) else logMismatch("rgbValid", 0, rgbValid);
      assert (go == 1'b0) else logMismatch("go", 0, go);
      assert (columnCount == '0) else logMismatch("columnCount", 0, columnCount);
      assert (lineCount == '0) else logMismatch("lineCount", 0, lineCount);
      endTest("reset values");

      // Three lines with frame-valid still low
      fillFrame();
      rowsSeen = 0;
      for (int row = 0; row < 3; row++)
         sendLine(row);
      idleCycles(12);
      @(negedge PIX_CLK);
      assert (go == 1'b0) else logMismatch("go", 0, go);
      assert (rowsSeen == 0) else failCheck("rows produced before the frame start");
      @(posedge PIX_CLK);
      pixFv <= 1'b1;
      idleCycles(2);
      @(posedge PIX_CLK);
      pixFv <= 1'b0;
      idleCycles(3);
      @(negedge PIX_CLK);
      assert (go == 1'b1) else logMismatch("go", 1, go);
      endTest("lines before frame start");

      for (int f = 1; f <= NumFrames; f++) begin
         sendFrame();
         endTest($sformatf("frame %0d", f));
      end

      $display("Tests run: %0d, tests failed: %0d, errors: %0d", testsRun, testsFailed, errCount);
      if (errCount == 0 && testsFailed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== cmosDemosaic.f ====
+incdir+.
cmosDemosaicPkg.sv
lineTimingIf.sv
lineReadIf.sv
pixelTiming.sv
lineRam.sv
lineBufferBank.sv
demosaicEngine.sv
cmosDemosaic.sv
cmosDemosaicTb.sv
